/* verilog/tetris_pkg.sv */
package tetris_pkg;

  //////////////////////////////////////////////////////////////////////
  // field geometry
  //////////////////////////////////////////////////////////////////////

  localparam int ROWS = 21;  // row 0 is the top of the screen
  localparam int COLS = 10;
  localparam int CW   = 3;   // colour bits, 0 is an empty cell

  // game flow
  typedef enum logic [2:0] {
    IDLE,
    READY,
    NEW_BLOCK,
    PLAY,
    LOCK,
    CLEAR,
    OVER
  } state_t;

  // one step of the falling piece
  typedef enum logic [2:0] {
    RIGHT,
    LEFT,
    ROR,
    ROL,
    DOWN,
    NONE = 3'b111  // no step this cycle
  } move_t;

  //////////////////////////////////////////////////////////////////////
  // piece shapes in rotation 0
  //////////////////////////////////////////////////////////////////////

  // 4x4 frame, cell (r,c) sits at bit r*4+c
  localparam logic [15:0] piece_shape [7] = '{
    16'h00f0,  // I, frame row 1
    16'h0066,  // O
    16'h0027,  // T
    16'h0036,  // S
    16'h0063,  // Z
    16'h0071,  // J
    16'h0074   // L
  };

  // n quarter turns clockwise, new(r,c) = old(3-c,r)
  function automatic logic [15:0] rot_mask(input logic [15:0] m, input logic [1:0] n);
    logic [15:0] cur;
    logic [15:0] nxt;
    cur = m;
    nxt = m;
    for (int k = 0; k < 3; k++) begin
      if (k < n) begin
        for (int r = 0; r < 4; r++) begin
          for (int c = 0; c < 4; c++) begin
            nxt[r*4+c] = cur[(3-c)*4+r];
          end
        end
        cur = nxt;
      end
    end
    return cur;
  endfunction

endpackage

/* verilog/grid_row.sv */
`timescale 1ns/10ps

module grid_row import tetris_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we_i,     // lock write strobe
  input  logic [COLS-1:0]        mask_i,   // cells of the locked piece in this row
  input  logic [CW-1:0]          color_i,
  input  logic                   shift_i,  // take the row above
  input  logic [COLS-1:0][CW-1:0] above_i,
  output logic [COLS-1:0][CW-1:0] row_o,
  output logic                   full_o
);

  // cell storage, cleared so the field starts empty
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      row_o <= '0;
    end else if (shift_i) begin
      row_o <= above_i;  // shift has priority
    end else if (we_i) begin
      for (int c = 0; c < COLS; c++) begin
        if (mask_i[c]) begin
          row_o[c] <= color_i;
        end
      end
    end
  end

  // full when no cell is empty
  always_comb begin
    full_o = 1'b1;
    for (int c = 0; c < COLS; c++) begin
      if (row_o[c] == '0) begin
        full_o = 1'b0;
      end
    end
  end

endmodule

/* verilog/line_clear.sv */
`timescale 1ns/10ps

module line_clear import tetris_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,  // one pulse after each lock
  input  logic [ROWS-1:0] full_i,
  output logic [ROWS-1:0] shift_o,
  output logic            busy_o,
  output logic [15:0]     lines_o
);

  localparam int RW = $clog2(ROWS);

  logic          armed;     // set by start, held while rows are full
  logic          any_full;
  logic [RW-1:0] low_idx;   // lowest full row on screen

  assign any_full = |full_i;
  assign busy_o   = armed & any_full;

  // highest index wins, that is the bottom-most full row
  always_comb begin
    low_idx = '0;
    for (int r = 0; r < ROWS; r++) begin
      if (full_i[r]) begin
        low_idx = RW'(r);
      end
    end
  end

  // rows 0..k move down one line, row k is dropped
  always_comb begin
    shift_o = '0;
    for (int r = 0; r < ROWS; r++) begin
      shift_o[r] = busy_o && (RW'(r) <= low_idx);
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      armed   <= 1'b0;
      lines_o <= '0;
    end else begin
      if (start_i) begin
        armed <= 1'b1;
      end else if (!any_full) begin
        armed <= 1'b0;  // field drained
      end
      if (busy_o) begin
        lines_o <= lines_o + 16'd1;  // one line per shift cycle
      end
    end
  end

endmodule

/* verilog/tetris_fsm.sv */
`timescale 1ns/10ps

module tetris_fsm import tetris_pkg::*; #(
  parameter int SPAWN_COL = 3
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             en_i,
  input  logic                             step_i,
  input  logic                             right_i,
  input  logic                             left_i,
  input  logic                             rr_i,
  input  logic                             rl_i,
  input  logic [ROWS-1:0][COLS-1:0][CW-1:0] grid_i,
  input  logic                             busy_i,
  output logic                             ready_o,
  output logic                             over_o,
  output logic                             lock_we_o,
  output logic                             start_o,
  output logic [ROWS-1:0][COLS-1:0]        lock_mask_o,
  output logic [CW-1:0]                    lock_color_o,
  output logic [2:0]                       piece_kind_o,
  output logic [4:0]                       piece_row_o,
  output logic signed [4:0]                piece_col_o,  // frame may hang left of col 0
  output logic [1:0]                       piece_rot_o
);

  state_t            state, state_nxt;
  move_t             mv;
  logic [2:0]        kind_cnt;  // next kind to spawn
  logic [2:0]        cand_kind;
  logic [4:0]        cand_row;
  logic signed [4:0] cand_col;
  logic [1:0]        cand_rot;
  logic [15:0]       cand_mask;
  logic              hit;       // candidate leaves field or overlaps
  logic              take;      // load candidate into the frame

  assign ready_o      = (state == PLAY);
  assign over_o       = (state == OVER);
  assign lock_we_o    = (state == LOCK);
  assign lock_color_o = CW'(piece_kind_o + 3'd1);

  //////////////////////////////////////////////////////////////////////
  // move decode and candidate frame
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mv = NONE;
    if (state == PLAY && step_i) begin
      if (right_i)     mv = RIGHT;
      else if (left_i) mv = LEFT;
      else if (rr_i)   mv = ROR;
      else if (rl_i)   mv = ROL;
      else             mv = DOWN;  // no level set, gravity
    end
  end

  always_comb begin
    cand_kind = piece_kind_o;
    cand_row  = piece_row_o;
    cand_col  = piece_col_o;
    cand_rot  = piece_rot_o;
    if (state == NEW_BLOCK) begin
      cand_kind = kind_cnt;   // spawn frame
      cand_row  = '0;
      cand_col  = 5'(SPAWN_COL);
      cand_rot  = '0;
    end else begin
      case (mv)
        RIGHT:   cand_col = piece_col_o + 5'sd1;
        LEFT:    cand_col = piece_col_o - 5'sd1;
        ROR:     cand_rot = piece_rot_o + 2'd1;
        ROL:     cand_rot = piece_rot_o - 2'd1;
        DOWN:    cand_row = piece_row_o + 5'd1;
        default: ;  // current frame, used for the lock mask
      endcase
    end
  end

  assign cand_mask = rot_mask(piece_shape[cand_kind], cand_rot);

  // bounds and overlap test, one pass over the 4x4 frame
  always_comb begin
    int fr;
    int fc;
    hit         = 1'b0;
    lock_mask_o = '0;
    for (int i = 0; i < 16; i++) begin
      fr = int'(cand_row) + i / 4;
      fc = int'(cand_col) + i % 4;  // sign kept
      if (cand_mask[i]) begin
        if (fr >= ROWS || fc < 0 || fc >= COLS) begin
          hit = 1'b1;
        end else if (grid_i[fr][fc] != '0) begin
          hit = 1'b1;
        end else begin
          lock_mask_o[fr][fc] = 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  assign take = (state == NEW_BLOCK) || (mv != NONE && !hit);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:      if (en_i) state_nxt = READY;
      READY:     if (en_i) state_nxt = NEW_BLOCK;
      NEW_BLOCK: state_nxt = hit ? OVER : PLAY;
      PLAY:      if (mv == DOWN && hit) state_nxt = LOCK;  // landed
      LOCK:      state_nxt = CLEAR;
      CLEAR:     if (!start_o && !busy_i) state_nxt = NEW_BLOCK;
      default:   state_nxt = state;  // OVER holds until reset
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state        <= IDLE;
      start_o      <= 1'b0;
      kind_cnt     <= '0;
      piece_kind_o <= '0;
      piece_row_o  <= '0;
      piece_col_o  <= '0;
      piece_rot_o  <= '0;
    end else begin
      state   <= state_nxt;
      start_o <= (state == LOCK);  // rows written on this edge
      if (state == NEW_BLOCK) begin
        kind_cnt <= (kind_cnt == 3'd6) ? 3'd0 : kind_cnt + 3'd1;
      end
      if (take) begin
        piece_kind_o <= cand_kind;
        piece_row_o  <= cand_row;
        piece_col_o  <= cand_col;
        piece_rot_o  <= cand_rot;
      end
    end
  end

endmodule

/* verilog/tetris_top.sv */
`timescale 1ns/10ps

module tetris_top import tetris_pkg::*; #(
  parameter int SPAWN_COL = 3
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             en_i,
  input  logic                             step_i,
  input  logic                             right_i,
  input  logic                             left_i,
  input  logic                             rr_i,
  input  logic                             rl_i,
  output logic [ROWS-1:0][COLS-1:0][CW-1:0] grid_o,
  output logic                             ready_o,
  output logic                             over_o,
  output logic [15:0]                      lines_o,
  output logic [2:0]                       piece_kind_o,
  output logic [4:0]                       piece_row_o,
  output logic signed [4:0]                piece_col_o,
  output logic [1:0]                       piece_rot_o
);

  logic                             lock_we;
  logic                             start;
  logic                             busy;
  logic [ROWS-1:0][COLS-1:0]        lock_mask;
  logic [CW-1:0]                    lock_color;
  logic [ROWS-1:0]                  full;
  logic [ROWS-1:0]                  shift;
  logic [ROWS-1:0][COLS-1:0][CW-1:0] above;  // row r sees row r-1

  assign above = {grid_o[ROWS-2:0], {(COLS*CW){1'b0}}};  // empty row feeds the top

  tetris_fsm #(
    .SPAWN_COL (SPAWN_COL)
  ) u_fsm (
    .clk          (clk),
    .rst          (rst),
    .en_i         (en_i),
    .step_i       (step_i),
    .right_i      (right_i),
    .left_i       (left_i),
    .rr_i         (rr_i),
    .rl_i         (rl_i),
    .grid_i       (grid_o),
    .busy_i       (busy),
    .ready_o      (ready_o),
    .over_o       (over_o),
    .lock_we_o    (lock_we),
    .start_o      (start),
    .lock_mask_o  (lock_mask),
    .lock_color_o (lock_color),
    .piece_kind_o (piece_kind_o),
    .piece_row_o  (piece_row_o),
    .piece_col_o  (piece_col_o),
    .piece_rot_o  (piece_rot_o)
  );

  // settled playfield, one module per row
  for (genvar r = 0; r < ROWS; r++) begin : g_row
    grid_row u_row (
      .clk     (clk),
      .rst     (rst),
      .we_i    (lock_we),
      .mask_i  (lock_mask[r]),
      .color_i (lock_color),
      .shift_i (shift[r]),
      .above_i (above[r]),
      .row_o   (grid_o[r]),
      .full_o  (full[r])
    );
  end

  line_clear u_clear (
    .clk     (clk),
    .rst     (rst),
    .start_i (start),
    .full_i  (full),
    .shift_o (shift),
    .busy_o  (busy),
    .lines_o (lines_o)
  );

endmodule

/* tb/tetris_props.sv */
`timescale 1ns/10ps

module tetris_props (
  input logic clk,
  input logic rst,
  input logic lock_we_i,
  input logic ready_i,
  input logic busy_i,
  input logic over_i
);

  int fails = 0;  // read by the testbench at the end

  a_lock_pulse: assert property (@(posedge clk) disable iff (rst) lock_we_i |=> !lock_we_i)
    else begin fails++; $error("lock write longer than one cycle"); end

  a_ready_busy: assert property (@(posedge clk) disable iff (rst) !(ready_i && busy_i))
    else begin fails++; $error("ready while line clear busy"); end

  a_over_hold: assert property (@(posedge clk) disable iff (rst) over_i |=> over_i)
    else begin fails++; $error("game over dropped before reset"); end

endmodule

bind tetris_top tetris_props u_props (
  .clk       (clk),
  .rst       (rst),
  .lock_we_i (lock_we),
  .ready_i   (ready_o),
  .busy_i    (busy),
  .over_i    (over_o)
);

/* tb/tetris_checker.sv */
`timescale 1ns/10ps

module tetris_checker import tetris_pkg::*; (
  input logic [ROWS-1:0][COLS-1:0][CW-1:0] grid_i,
  input logic                              ready_i,
  input logic                              over_i,
  input logic [15:0]                       lines_i,
  input logic [2:0]                        kind_i,
  input logic [4:0]                        row_i,
  input logic signed [4:0]                 col_i,
  input logic [1:0]                        rot_i
);

  int errors = 0;

  // one settled row with col 9 in the top bits
  task automatic compare_row(input int r, input logic [29:0] exp);
    if (grid_i[r] !== exp) begin
      $display("mismatch at %0t: row %0d is %h, expected %h", $time, r, grid_i[r], exp);
      errors++;
    end
  endtask

  task automatic match_piece(input int k, input int r, input int c, input int rot);
    if (kind_i != k || row_i != r || int'(col_i) != c || rot_i != rot) begin
      $display("mismatch at %0t: piece %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
               $time, kind_i, row_i, col_i, rot_i, k, r, c, rot);
      errors++;
    end
  endtask

  task automatic verify_lines(input int n);
    if (lines_i != n) begin
      $display("mismatch at %0t: lines %0d, expected %0d", $time, lines_i, n);
      errors++;
    end
  endtask

  // nothing ready and no game over right after reset
  task automatic idle_outputs();
    if (ready_i || over_i) begin
      $display("mismatch at %0t: over %b ready %b, expected over 0 ready 0",
               $time, over_i, ready_i);
      errors++;
    end
  endtask

  // game over means no more steps taken
  task automatic confirm_over();
    if (!over_i || ready_i) begin
      $display("mismatch at %0t: over %b ready %b, expected over 1 ready 0",
               $time, over_i, ready_i);
      errors++;
    end
  endtask

endmodule

/* tb/tetris_tb.sv */
`timescale 1ns/10ps

module tetris_tb import tetris_pkg::*; ();

  logic                              clk;
  logic                              rst;
  logic                              en_i;
  logic                              step_i;
  logic                              right_i;
  logic                              left_i;
  logic                              rr_i;
  logic                              rl_i;
  logic [ROWS-1:0][COLS-1:0][CW-1:0] grid_o;
  logic                              ready_o;
  logic                              over_o;
  logic [15:0]                       lines_o;
  logic [2:0]                        piece_kind_o;
  logic [4:0]                        piece_row_o;
  logic signed [4:0]                 piece_col_o;
  logic [1:0]                        piece_rot_o;

  int cycles;     // free running for the timeout
  int limit;      // 40 cycles per data line
  int tb_errors;  // timeout and file problems

  tetris_top #(.SPAWN_COL(3)) DUT (.*);

  tetris_checker chk (
    .grid_i  (grid_o),
    .ready_i (ready_o),
    .over_i  (over_o),
    .lines_i (lines_o),
    .kind_i  (piece_kind_o),
    .row_i   (piece_row_o),
    .col_i   (piece_col_o),
    .rot_i   (piece_rot_o)
  );

  always #2 clk = ~clk;  // 4 ns period

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic pulse_en();
    @(posedge clk);
    en_i <= 1'b1;
    @(posedge clk);
    en_i <= 1'b0;
  endtask

  // hold step with the move levels for n cycles
  task automatic apply_step(input logic [7:0] mv, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      step_i  <= 1'b1;
      right_i <= (mv == "r");
      left_i  <= (mv == "l");
      rr_i    <= (mv == "c");  // rotate right
      rl_i    <= (mv == "a");  // rotate left
    end
    @(posedge clk);
    step_i  <= 1'b0;
    right_i <= 1'b0;
    left_i  <= 1'b0;
    rr_i    <= 1'b0;
    rl_i    <= 1'b0;
  endtask

  task automatic wait_ready();
    @(negedge clk);
    while (!(ready_o || over_o)) begin
      @(negedge clk);
    end
  endtask

  // closing line and then the verdict
  task automatic finish_run();
    int total;
    total = chk.errors + DUT.u_props.fails + tb_errors;
    $display("errors: checker %0d, assertions %0d, testbench %0d",
             chk.errors, DUT.u_props.fails, tb_errors);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: DUT never became ready");
      tb_errors = tb_errors + 1;
      finish_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // command interpreter
  //////////////////////////////////////////////////////////////////////

  initial begin
    int            fd;
    int            n;
    int            nlines;
    int            a;
    int            b;
    int            c;
    int            d;
    logic [63:0]   tok;
    logic [7:0]    mv;
    logic [29:0]   hex;
    logic [1023:0] line;
    clk       = 1'b0;
    rst       = 1'b1;
    en_i      = 1'b0;
    step_i    = 1'b0;
    right_i   = 1'b0;
    left_i    = 1'b0;
    rr_i      = 1'b0;
    rl_i      = 1'b0;
    cycles    = 0;
    limit     = 0;
    tb_errors = 0;
    nlines    = 0;
    fd = $fopen("tb/tetris_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the testdata file");
      tb_errors = 1;
    end else begin
      while (!$feof(fd)) begin  // first pass sizes the timeout
        n = $fgets(line, fd);
        if (n > 0) nlines++;
      end
      $fclose(fd);
      limit = 40 * nlines;
      fd = $fopen("tb/tetris_testdata.txt", "r");
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      // empty field and quiet outputs once reset drops
      @(negedge clk);
      for (int r = 0; r < ROWS; r++) begin
        chk.compare_row(r, '0);
      end
      chk.idle_outputs();
      while ($fscanf(fd, " %s", tok) == 1) begin
        case (tok)
          "#": n = $fgets(line, fd);  // comment line
          "E": pulse_en();
          "W": wait_ready();
          "S": begin
            n = $fscanf(fd, " %s %d", mv, a);
            apply_step(mv, a);
          end
          "R": begin
            n = $fscanf(fd, " %d %h", a, hex);
            @(negedge clk);
            chk.compare_row(a, hex);
          end
          "P": begin
            n = $fscanf(fd, " %d %d %d %d", a, b, c, d);
            @(negedge clk);
            chk.match_piece(a, b, c, d);
          end
          "L": begin
            n = $fscanf(fd, " %d", a);
            @(negedge clk);
            chk.verify_lines(a);
          end
          "O": begin
            @(negedge clk);
            chk.confirm_over();
          end
          default: begin
            $display("unknown command in the testdata file");
            tb_errors = tb_errors + 1;
          end
        endcase
      end
      $fclose(fd);
    end
    finish_run();
  end

endmodule

/* tb/tetris_testdata.txt */
# E en, W wait ready/over, S move count (r l c=ror a=rol d=down), O over
# R row hex30, P kind row col rot, L lines
L 0
E
E
W
P 0 0 3 0
S r 4
P 0 0 6 0
S l 7
P 0 0 0 0
S c 1
P 0 0 0 1
S a 1
P 0 0 0 0
S c 1
S l 3
S c 1
P 0 0 -2 1
S r 5
S a 1
S l 1
P 0 0 2 0
S d 20
W
R 20 00009240
P 1 0 3 0
S l 4
S d 20
W
S c 2
S r 2
P 2 0 5 2
S d 18
W
S c 1
S r 4
P 3 0 6 1
S d 19
W
L 1
R 20 24600012
R 19 04000000
P 4 0 3 0
S d 300
W
O
P 1 0 3 0
R 1 00049200
L 1

/* sources.f */
verilog/tetris_pkg.sv
verilog/grid_row.sv
verilog/line_clear.sv
verilog/tetris_fsm.sv
verilog/tetris_top.sv
tb/tetris_props.sv
tb/tetris_checker.sv
tb/tetris_tb.sv

/* Bender.yml */
package:
  name: tetris

sources:
  - verilog/tetris_pkg.sv
  - verilog/grid_row.sv
  - verilog/line_clear.sv
  - verilog/tetris_fsm.sv
  - verilog/tetris_top.sv
  - target: simulation
    files:
      - tb/tetris_props.sv
      - tb/tetris_checker.sv
      - tb/tetris_tb.sv
